// ==== core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and instruction width
`define CORE_XLEN 32

// register file geometry
`define CORE_REG_AW 5
`define CORE_NUM_REGS 32

// edges from acceptance to the retirement port
`define CORE_WB_LATENCY 3

`endif

// ==== isa_pkg.sv ====
package isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // selects sub and sra
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // field positions
    localparam int OPC_LSB   = 0;
    localparam int RD_LSB    = 7;
    localparam int F3_LSB    = 12;
    localparam int RS1_LSB   = 15;
    localparam int RS2_LSB   = 20;
    localparam int F7_LSB    = 25;
    localparam int IMM_I_LSB = 20;
    localparam int IMM_U_LSB = 12;

endpackage

// ==== core_types_pkg.sv ====
`include "core_params.svh"

package core_types_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        ALU_SRA    = 4'd9,
        // lui passes the immediate through
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // operand source selects from hazard control
    localparam logic [1:0] SRC_RF = 2'd0;
    localparam logic [1:0] SRC_LS = 2'd1;
    localparam logic [1:0] SRC_WB = 2'd2;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_REG_AW-1:0] rd;
        logic                    dest_wen;
        alu_op_e                 op;
        logic [`CORE_XLEN-1:0]   operand1;
        logic [`CORE_XLEN-1:0]   operand2;
    } id_ex_t;

endpackage

// ==== stage_bus_if.sv ====
`include "core_params.svh"

interface stage_bus_if;

    logic                    valid;
    logic [`CORE_REG_AW-1:0] rd;
    logic                    dest_wen;
    logic [`CORE_XLEN-1:0]   data;

    modport producer (
        output valid,
        output rd,
        output dest_wen,
        output data
    );

    modport observer (
        input valid,
        input rd,
        input dest_wen,
        input data
    );

endinterface

// ==== hazard_ctrl.sv ====
`include "core_params.svh"

module hazard_ctrl (
    input  logic [`CORE_REG_AW-1:0] rs1,
    input  logic [`CORE_REG_AW-1:0] rs2,
    input  logic                    rs1_used,
    input  logic                    rs2_used,
    input  logic                    inst_valid,
    input  core_types_pkg::id_ex_t  id_ex,
    stage_bus_if.observer           ls_bus,
    stage_bus_if.observer           wb_bus,
    output logic                    decode_block,
    output logic [1:0]              src1_sel,
    output logic [1:0]              src2_sel
);

    logic rs1_live;
    logic rs2_live;
    logic ex_hit1;
    logic ex_hit2;
    logic ls_hit1;
    logic ls_hit2;
    logic wb_hit1;
    logic wb_hit2;

    function automatic logic dest_match(
        input logic                    live,
        input logic [`CORE_REG_AW-1:0] src,
        input logic                    valid,
        input logic                    wen,
        input logic [`CORE_REG_AW-1:0] rd
    );
        return live && valid && wen && (rd == src);
    endfunction

    // load/store holds the younger result
    function automatic logic [1:0] nearest(input logic ls_hit, input logic wb_hit);
        if (ls_hit) begin
            return core_types_pkg::SRC_LS;
        end
        return wb_hit ? core_types_pkg::SRC_WB : core_types_pkg::SRC_RF;
    endfunction

    // x0 never matches
    assign rs1_live = rs1_used && (rs1 != '0);
    assign rs2_live = rs2_used && (rs2 != '0);

    assign ex_hit1 = dest_match(rs1_live, rs1, id_ex.valid, id_ex.dest_wen, id_ex.rd);
    assign ex_hit2 = dest_match(rs2_live, rs2, id_ex.valid, id_ex.dest_wen, id_ex.rd);
    assign ls_hit1 = dest_match(rs1_live, rs1, ls_bus.valid, ls_bus.dest_wen, ls_bus.rd);
    assign ls_hit2 = dest_match(rs2_live, rs2, ls_bus.valid, ls_bus.dest_wen, ls_bus.rd);
    assign wb_hit1 = dest_match(rs1_live, rs1, wb_bus.valid, wb_bus.dest_wen, wb_bus.rd);
    assign wb_hit2 = dest_match(rs2_live, rs2, wb_bus.valid, wb_bus.dest_wen, wb_bus.rd);

    // execute result not ready yet so hold decode one cycle
    assign decode_block = inst_valid && (ex_hit1 || ex_hit2);

    assign src1_sel = nearest(ls_hit1, wb_hit1);
    assign src2_sel = nearest(ls_hit2, wb_hit2);

endmodule

// ==== inst_decode.sv ====
`include "core_params.svh"

module inst_decode (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic                    inst_valid,
    input  logic [`CORE_XLEN-1:0]   inst,
    input  logic                    decode_block,
    input  logic [1:0]              src1_sel,
    input  logic [1:0]              src2_sel,
    input  logic [`CORE_XLEN-1:0]   rf_rdata1,
    input  logic [`CORE_XLEN-1:0]   rf_rdata2,
    stage_bus_if.observer           ls_bus,
    stage_bus_if.observer           wb_bus,
    output logic [`CORE_REG_AW-1:0] rs1,
    output logic [`CORE_REG_AW-1:0] rs2,
    output logic                    rs1_used,
    output logic                    rs2_used,
    output core_types_pkg::id_ex_t  id_ex
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   imm_i;
    logic [`CORE_XLEN-1:0]   imm_u;
    logic                    f7_zero;
    logic                    f7_alt;
    logic                    legal;
    logic                    use_imm;
    logic [`CORE_XLEN-1:0]   imm;
    core_types_pkg::alu_op_e op_d;
    logic [`CORE_XLEN-1:0]   src1_val;
    logic [`CORE_XLEN-1:0]   src2_val;
    logic                    load;

    logic                    valid_q;
    logic                    dest_wen_q;
    logic [`CORE_REG_AW-1:0] rd_q;
    core_types_pkg::alu_op_e op_q;
    logic [`CORE_XLEN-1:0]   operand1_q;
    logic [`CORE_XLEN-1:0]   operand2_q;

    function automatic core_types_pkg::alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
            isa_pkg::F3_ADD_SUB: begin
                return alt ? core_types_pkg::ALU_SUB : core_types_pkg::ALU_ADD;
            end
            isa_pkg::F3_SLL:  return core_types_pkg::ALU_SLL;
            isa_pkg::F3_SLT:  return core_types_pkg::ALU_SLT;
            isa_pkg::F3_SLTU: return core_types_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:  return core_types_pkg::ALU_XOR;
            isa_pkg::F3_SRL_SRA: begin
                return alt ? core_types_pkg::ALU_SRA : core_types_pkg::ALU_SRL;
            end
            isa_pkg::F3_OR:   return core_types_pkg::ALU_OR;
            default:          return core_types_pkg::ALU_AND;
        endcase
    endfunction

    function automatic logic [`CORE_XLEN-1:0] pick_src(
        input logic [1:0]            sel,
        input logic [`CORE_XLEN-1:0] rf,
        input logic [`CORE_XLEN-1:0] ls,
        input logic [`CORE_XLEN-1:0] wb
    );
        case (sel)
            core_types_pkg::SRC_LS: return ls;
            core_types_pkg::SRC_WB: return wb;
            default:                return rf;
        endcase
    endfunction

    assign opcode = inst[isa_pkg::OPC_LSB +: 7];
    assign rd     = inst[isa_pkg::RD_LSB +: `CORE_REG_AW];
    assign funct3 = inst[isa_pkg::F3_LSB +: 3];
    assign rs1    = inst[isa_pkg::RS1_LSB +: `CORE_REG_AW];
    assign rs2    = inst[isa_pkg::RS2_LSB +: `CORE_REG_AW];
    assign funct7 = inst[isa_pkg::F7_LSB +: 7];

    assign imm_i = {{(`CORE_XLEN-12){inst[`CORE_XLEN-1]}}, inst[isa_pkg::IMM_I_LSB +: 12]};
    assign imm_u = {inst[isa_pkg::IMM_U_LSB +: 20], 12'b0};

    assign f7_zero = (funct7 == 7'b0);
    assign f7_alt  = (funct7 == isa_pkg::FUNCT7_ALT);

    always_comb begin
        legal    = 1'b0;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        use_imm  = 1'b0;
        imm      = imm_i;
        op_d     = core_types_pkg::ALU_ADD;
        case (opcode)
            isa_pkg::OPC_OP: begin
                legal    = f7_zero || (f7_alt && (funct3 == isa_pkg::F3_ADD_SUB ||
                                                  funct3 == isa_pkg::F3_SRL_SRA));
                rs1_used = legal;
                rs2_used = legal;
                op_d     = f3_to_op(funct3, f7_alt);
            end
            isa_pkg::OPC_OP_IMM: begin
                // upper bits are immediate except on shifts
                if (funct3 == isa_pkg::F3_SLL) begin
                    legal = f7_zero;
                end else if (funct3 == isa_pkg::F3_SRL_SRA) begin
                    legal = f7_zero || f7_alt;
                end else begin
                    legal = 1'b1;
                end
                rs1_used = legal;
                use_imm  = 1'b1;
                op_d     = f3_to_op(funct3, f7_alt && (funct3 == isa_pkg::F3_SRL_SRA));
            end
            isa_pkg::OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                imm     = imm_u;
                op_d    = core_types_pkg::ALU_PASS_B;
            end
            default: legal = 1'b0;
        endcase
    end

    assign src1_val = pick_src(src1_sel, rf_rdata1, ls_bus.data, wb_bus.data);
    assign src2_val = pick_src(src2_sel, rf_rdata2, ls_bus.data, wb_bus.data);

    // bubble when idle or blocked
    assign load = inst_valid && !decode_block;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            valid_q    <= 1'b0;
            dest_wen_q <= 1'b0;
        end else begin
            valid_q    <= load;
            dest_wen_q <= load && legal && (rd != '0);
        end
    end

    always_ff @(posedge sys_clk) begin
        rd_q       <= rd;
        op_q       <= op_d;
        operand1_q <= src1_val;
        operand2_q <= use_imm ? imm : src2_val;
    end

    assign id_ex = '{
        valid:    valid_q,
        rd:       rd_q,
        dest_wen: dest_wen_q,
        op:       op_q,
        operand1: operand1_q,
        operand2: operand2_q
    };

endmodule

// ==== exec_stage.sv ====
`include "core_params.svh"

module exec_stage (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  core_types_pkg::id_ex_t id_ex,
    stage_bus_if.producer          ls_bus,
    stage_bus_if.producer          wb_bus
);

    localparam int SHAMT_W = $clog2(`CORE_XLEN);

    logic [`CORE_XLEN-1:0]   op_a;
    logic [`CORE_XLEN-1:0]   op_b;
    logic [SHAMT_W-1:0]      shamt;
    logic                    slt_bit;
    logic                    sltu_bit;
    logic [`CORE_XLEN-1:0]   alu_result;

    logic                    ls_valid_q;
    logic                    ls_dest_wen_q;
    logic [`CORE_REG_AW-1:0] ls_rd_q;
    logic [`CORE_XLEN-1:0]   ls_data_q;
    logic                    wb_valid_q;
    logic                    wb_dest_wen_q;
    logic [`CORE_REG_AW-1:0] wb_rd_q;
    logic [`CORE_XLEN-1:0]   wb_data_q;

    assign op_a     = id_ex.operand1;
    assign op_b     = id_ex.operand2;
    assign shamt    = op_b[SHAMT_W-1:0];
    assign slt_bit  = $signed(op_a) < $signed(op_b);
    assign sltu_bit = op_a < op_b;

    always_comb begin
        case (id_ex.op)
            core_types_pkg::ALU_ADD:    alu_result = op_a + op_b;
            core_types_pkg::ALU_SUB:    alu_result = op_a - op_b;
            core_types_pkg::ALU_AND:    alu_result = op_a & op_b;
            core_types_pkg::ALU_OR:     alu_result = op_a | op_b;
            core_types_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            core_types_pkg::ALU_SLT:    alu_result = {{(`CORE_XLEN-1){1'b0}}, slt_bit};
            core_types_pkg::ALU_SLTU:   alu_result = {{(`CORE_XLEN-1){1'b0}}, sltu_bit};
            core_types_pkg::ALU_SLL:    alu_result = op_a << shamt;
            core_types_pkg::ALU_SRL:    alu_result = op_a >> shamt;
            core_types_pkg::ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
            core_types_pkg::ALU_PASS_B: alu_result = op_b;
            default:                    alu_result = '0;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ls_valid_q    <= 1'b0;
            ls_dest_wen_q <= 1'b0;
            wb_valid_q    <= 1'b0;
            wb_dest_wen_q <= 1'b0;
        end else begin
            ls_valid_q    <= id_ex.valid;
            ls_dest_wen_q <= id_ex.dest_wen;
            wb_valid_q    <= ls_valid_q;
            wb_dest_wen_q <= ls_dest_wen_q;
        end
    end

    always_ff @(posedge sys_clk) begin
        ls_rd_q   <= id_ex.rd;
        ls_data_q <= alu_result;
        wb_rd_q   <= ls_rd_q;
        wb_data_q <= ls_data_q;
    end

    // buses announce only instructions that write a register
    assign ls_bus.valid    = ls_valid_q && ls_dest_wen_q;
    assign ls_bus.rd       = ls_rd_q;
    assign ls_bus.dest_wen = ls_dest_wen_q;
    assign ls_bus.data     = ls_data_q;

    assign wb_bus.valid    = wb_valid_q && wb_dest_wen_q;
    assign wb_bus.rd       = wb_rd_q;
    assign wb_bus.dest_wen = wb_dest_wen_q;
    assign wb_bus.data     = wb_data_q;

endmodule

// ==== gpr_file.sv ====
`include "core_params.svh"

module gpr_file (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic [`CORE_REG_AW-1:0] rs1,
    input  logic [`CORE_REG_AW-1:0] rs2,
    output logic [`CORE_XLEN-1:0]   rf_rdata1,
    output logic [`CORE_XLEN-1:0]   rf_rdata2,
    stage_bus_if.observer           wb_bus
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];
    logic                  wr_en;

    // x0 is never written
    assign wr_en = wb_bus.valid && wb_bus.dest_wen && (wb_bus.rd != '0);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_bus.rd] <= wb_bus.data;
        end
    end

    // async read ports
    assign rf_rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rf_rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== rv_core_top.sv ====
`include "core_params.svh"

module rv_core_top (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic                    inst_valid,
    input  logic [`CORE_XLEN-1:0]   inst,
    output logic                    inst_ready,
    output logic                    wb_valid,
    output logic [`CORE_REG_AW-1:0] wb_rd,
    output logic [`CORE_XLEN-1:0]   wb_data
);

    logic [`CORE_REG_AW-1:0] rs1;
    logic [`CORE_REG_AW-1:0] rs2;
    logic                    rs1_used;
    logic                    rs2_used;
    logic                    decode_block;
    logic [1:0]              src1_sel;
    logic [1:0]              src2_sel;
    logic [`CORE_XLEN-1:0]   rf_rdata1;
    logic [`CORE_XLEN-1:0]   rf_rdata2;
    core_types_pkg::id_ex_t  id_ex;

    // results of the load/store and writeback stages
    stage_bus_if ls_bus ();
    stage_bus_if wb_bus ();

    hazard_ctrl i_hazard_ctrl (
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_used     (rs1_used),
        .rs2_used     (rs2_used),
        .inst_valid   (inst_valid),
        .id_ex        (id_ex),
        .ls_bus       (ls_bus.observer),
        .wb_bus       (wb_bus.observer),
        .decode_block (decode_block),
        .src1_sel     (src1_sel),
        .src2_sel     (src2_sel)
    );

    inst_decode i_inst_decode (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .decode_block (decode_block),
        .src1_sel     (src1_sel),
        .src2_sel     (src2_sel),
        .rf_rdata1    (rf_rdata1),
        .rf_rdata2    (rf_rdata2),
        .ls_bus       (ls_bus.observer),
        .wb_bus       (wb_bus.observer),
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_used     (rs1_used),
        .rs2_used     (rs2_used),
        .id_ex        (id_ex)
    );

    exec_stage i_exec_stage (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .id_ex     (id_ex),
        .ls_bus    (ls_bus.producer),
        .wb_bus    (wb_bus.producer)
    );

    gpr_file i_gpr_file (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .wb_bus    (wb_bus.observer)
    );

    assign inst_ready = ~decode_block;

    // retirement port
    assign wb_valid = wb_bus.valid;
    assign wb_rd    = wb_bus.rd;
    assign wb_data  = wb_bus.data;

endmodule

// ==== tb_rv_core.sv ====
`include "core_params.svh"

module tb_rv_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES    = 16;
    localparam int RANDOM_COUNT    = 300;
    localparam int DIRECTED_COUNT  = 55;
    localparam int NUM_INSTR       = DIRECTED_COUNT + RANDOM_COUNT;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_INSTR * 4 + 200;
    localparam logic [31:0] SEED   = 32'h9112_58f3;

    typedef struct packed {
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   data;
        int                      due;
    } ret_t;

    logic                    sys_clk;
    logic                    sys_rst_n;
    logic                    inst_valid;
    logic [`CORE_XLEN-1:0]   inst;
    logic                    inst_ready;
    logic                    wb_valid;
    logic [`CORE_REG_AW-1:0] wb_rd;
    logic [`CORE_XLEN-1:0]   wb_data;

    // reference model state
    logic [`CORE_XLEN-1:0]   arch [`CORE_NUM_REGS];
    ret_t                    exp_q [$];
    logic [`CORE_REG_AW-1:0] ex_rd;

    // check values, updated on the falling edge
    logic                    fresh_reset;
    logic                    exp_ready;
    logic                    exp_present;
    logic [`CORE_REG_AW-1:0] exp_rd;
    logic [`CORE_XLEN-1:0]   exp_data;
    int                      exp_due;
    logic                    late_entry;
    logic [`CORE_REG_AW-1:0] late_rd;

    int    cycle;
    int    errors;
    int    retired;
    int    tests_run;
    int    test_base;
    string test_name;

    rv_core_top i_dut (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    always #5 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycle <= cycle + 1;
    end

    a_reset: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        fresh_reset |-> (!wb_valid && inst_ready))
        else begin
            errors++;
            $display("[FAIL] %s: after reset wb_valid expected 0 actual %0b, inst_ready expected 1 actual %0b",
                     test_name, $sampled(wb_valid), $sampled(inst_ready));
        end

    a_ready: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        inst_ready == exp_ready)
        else begin
            errors++;
            $display("[FAIL] %s: inst_ready expected %0b actual %0b",
                     test_name, $sampled(exp_ready), $sampled(inst_ready));
        end

    a_stall_one: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (inst_valid && !inst_ready) |=> inst_ready)
        else begin
            errors++;
            $display("%s: inst_ready stayed low for more than one cycle", test_name);
        end

    a_spurious: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        wb_valid |-> exp_present)
        else begin
            errors++;
            $display("%s: wb_valid rose for x%0d with no retirement pending",
                     test_name, $sampled(wb_rd));
        end

    a_rd: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (wb_valid && exp_present) |-> (wb_rd == exp_rd))
        else begin
            errors++;
            $display("[FAIL] %s: wb_rd expected %0d actual %0d",
                     test_name, $sampled(exp_rd), $sampled(wb_rd));
        end

    a_data: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (wb_valid && exp_present) |-> (wb_data == exp_data))
        else begin
            errors++;
            $display("[FAIL] %s: wb_data expected %08h actual %08h",
                     test_name, $sampled(exp_data), $sampled(wb_data));
        end

    a_latency: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (wb_valid && exp_present) |-> (exp_due == cycle))
        else begin
            errors++;
            $display("[FAIL] %s: retirement cycle expected %0d actual %0d",
                     test_name, $sampled(exp_due), $sampled(cycle));
        end

    a_missing: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !late_entry)
        else begin
            errors++;
            $display("%s: expected retirement of x%0d never appeared",
                     test_name, $sampled(late_rd));
        end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, isa_pkg::OPC_LUI};
    endfunction

    // RV32I encoding rules for the supported subset
    function automatic logic is_legal(input logic [31:0] w);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        case (opc)
            isa_pkg::OPC_OP: begin
                return (f7 == 7'h00) ||
                       (f7 == isa_pkg::FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5));
            end
            isa_pkg::OPC_OP_IMM: begin
                if (f3 == 3'd1) begin
                    return f7 == 7'h00;
                end
                if (f3 == 3'd5) begin
                    return (f7 == 7'h00) || (f7 == isa_pkg::FUNCT7_ALT);
                end
                return 1'b1;
            end
            isa_pkg::OPC_LUI: return 1'b1;
            default:          return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic [31:0]        sra_v;
        logic [4:0]         sh;
        sa    = a;
        sh    = b[4:0];
        sra_v = sa >>> sh;
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? sra_v : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // retire into the model in acceptance order
    task automatic model_exec(input logic [31:0] w, input int accept_cycle);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] res;
        ret_t        e;
        opc = w[6:0];
        f3  = w[14:12];
        rd  = w[11:7];
        res = '0;
        case (opc)
            isa_pkg::OPC_OP: res = alu_ref(f3, w[30], arch[w[19:15]], arch[w[24:20]]);
            isa_pkg::OPC_OP_IMM: begin
                res = alu_ref(f3, w[30] && f3 == 3'd5, arch[w[19:15]],
                              {{20{w[31]}}, w[31:20]});
            end
            isa_pkg::OPC_LUI: res = {w[31:12], 12'b0};
            default: res = '0;
        endcase
        ex_rd = 5'd0;
        if (is_legal(w) && rd != 5'd0) begin
            arch[rd] = res;
            ex_rd    = rd;
            e.rd     = rd;
            e.data   = res;
            e.due    = accept_cycle + `CORE_WB_LATENCY;
            exp_q.push_back(e);
        end
    endtask

    // one clock cycle of stimulus and bookkeeping
    task automatic step(input logic v, input logic [31:0] w, output logic taken);
        logic       legal;
        logic       use1;
        logic       use2;
        logic [6:0] opc;
        ret_t       head;
        @(negedge sys_clk);
        fresh_reset = 1'b0;
        exp_present = 1'b0;
        if (wb_valid && exp_q.size() > 0) begin
            head        = exp_q.pop_front();
            exp_present = 1'b1;
            exp_rd      = head.rd;
            exp_data    = head.data;
            exp_due     = head.due;
            retired++;
        end
        late_entry = (exp_q.size() > 0) && (exp_q[0].due <= cycle);
        if (late_entry) begin
            late_rd = exp_q[0].rd;
            void'(exp_q.pop_front());
        end
        inst_valid = v;
        inst       = w;
        opc        = w[6:0];
        legal      = is_legal(w);
        use1       = legal && (opc == isa_pkg::OPC_OP || opc == isa_pkg::OPC_OP_IMM);
        use2       = legal && (opc == isa_pkg::OPC_OP);
        // distance one dependency holds decode
        exp_ready  = !(v && ex_rd != 5'd0 &&
                       ((use1 && w[19:15] == ex_rd) || (use2 && w[24:20] == ex_rd)));
        #1;
        taken = v && inst_ready;
        if (taken) begin
            model_exec(w, cycle);
        end else begin
            ex_rd = 5'd0;
        end
    endtask

    task automatic send(input logic [31:0] w);
        logic taken;
        int   tries;
        taken = 1'b0;
        tries = 0;
        while (!taken && tries < 4) begin
            step(1'b1, w, taken);
            tries++;
        end
        if (!taken) begin
            errors++;
            $display("%s: instruction %08h was not accepted within 4 cycles", test_name, w);
        end
    endtask

    task automatic idle(input int n);
        logic taken;
        repeat (n) begin
            step(1'b0, '0, taken);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < 2 * `CORE_WB_LATENCY) begin
            idle(1);
            n++;
        end
        idle(1);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_base = errors;
    endtask

    task automatic end_test();
        drain();
        tests_run++;
        $display("test %-12s %s (%0d errors)", test_name,
                 (errors == test_base) ? "ok" : "failed", errors - test_base);
    endtask

    // random op over x0..x7
    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r   = $urandom();
        s   = $urandom();
        f3  = r[2:0];
        rd  = {2'b00, r[5:3]};
        rs1 = {2'b00, r[8:6]};
        rs2 = {2'b00, r[11:9]};
        f7  = (r[15] && (f3 == 3'd0 || f3 == 3'd5)) ? isa_pkg::FUNCT7_ALT : 7'h00;
        case (r[14:12])
            3'd0, 3'd1, 3'd2: return r_type(f7, rs2, rs1, f3, rd);
            3'd3, 3'd4, 3'd5: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    return i_type({f7, s[4:0]}, rs1, f3, rd);
                end
                return i_type(s[11:0], rs1, f3, rd);
            end
            3'd6:    return u_type(s[19:0], rd);
            default: return r[16] ? {s[31:7], 7'b0000011} : i_type(s[11:0], 5'd0, 3'd0, rd);
        endcase
    endfunction

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        logic [11:0] imm;
        logic        taken;
        sys_clk     = 1'b0;
        sys_rst_n   = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        ex_rd       = '0;
        fresh_reset = 1'b0;
        exp_ready   = 1'b1;
        exp_present = 1'b0;
        exp_rd      = '0;
        exp_data    = '0;
        exp_due     = 0;
        late_entry  = 1'b0;
        late_rd     = '0;
        errors      = 0;
        retired     = 0;
        tests_run   = 0;
        test_base   = 0;
        test_name   = "reset";
        void'($urandom(SEED));
        for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            arch[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst_n   = 1'b1;
        fresh_reset = 1'b1;

        start_test("independent");
        send(i_type(12'h123, 5'd0, 3'd0, 5'd1));
        send(i_type(12'hffb, 5'd0, 3'd0, 5'd2));
        send(u_type(20'h8abcd, 5'd3));
        send(i_type(12'h013, 5'd0, 3'd6, 5'd4));
        idle(4);
        for (int f = 0; f < 8; f++) begin
            send(r_type(7'h00, 5'd2, 5'd3, 3'(f), 5'(8 + f)));
        end
        send(r_type(isa_pkg::FUNCT7_ALT, 5'd4, 5'd1, 3'd0, 5'd16));
        send(r_type(isa_pkg::FUNCT7_ALT, 5'd4, 5'd3, 3'd5, 5'd17));
        for (int f = 0; f < 8; f++) begin
            rnd = $urandom();
            imm = (f == 1 || f == 5) ? {7'h00, rnd[4:0]} : rnd[11:0];
            send(i_type(imm, 5'd3, 3'(f), 5'(18 + f)));
        end
        send(i_type({isa_pkg::FUNCT7_ALT, 5'd7}, 5'd3, 3'd5, 5'd26));
        send(u_type(20'h00042, 5'd27));
        end_test();

        start_test("bypass");
        send(i_type(12'd77, 5'd0, 3'd0, 5'd5));
        send(i_type(12'hffe, 5'd0, 3'd0, 5'd6));
        send(r_type(7'h00, 5'd5, 5'd5, 3'd0, 5'd7));
        send(r_type(7'h00, 5'd0, 5'd6, 3'd4, 5'd8));
        send(r_type(isa_pkg::FUNCT7_ALT, 5'd5, 5'd6, 3'd0, 5'd9));
        send(r_type(7'h00, 5'd6, 5'd7, 3'd3, 5'd10));
        send(r_type(7'h00, 5'd9, 5'd0, 3'd0, 5'd11));
        // younger of two x12 writers in flight wins
        send(i_type(12'd1, 5'd0, 3'd0, 5'd12));
        send(i_type(12'd2, 5'd0, 3'd0, 5'd12));
        send(i_type(12'd0, 5'd0, 3'd0, 5'd13));
        send(r_type(7'h00, 5'd12, 5'd12, 3'd0, 5'd14));
        end_test();

        start_test("stall");
        send(i_type(12'd5, 5'd0, 3'd0, 5'd15));
        send(i_type(12'd1, 5'd15, 3'd0, 5'd16));
        send(r_type(7'h00, 5'd16, 5'd15, 3'd1, 5'd17));
        send(r_type(7'h00, 5'd17, 5'd17, 3'd2, 5'd18));
        end_test();

        start_test("x0");
        send(i_type(12'd5, 5'd1, 3'd0, 5'd0));
        send(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        send(32'h0000_a003);
        send(32'hffff_ffff);
        send(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd21));
        send(i_type(12'd3, 5'd0, 3'd0, 5'd19));
        send(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd20));
        send(r_type(isa_pkg::FUNCT7_ALT, 5'd1, 5'd0, 3'd0, 5'd22));
        end_test();

        start_test("latency");
        for (int k = 0; k < 8; k++) begin
            rnd = $urandom();
            send(u_type(rnd[19:0], 5'(22 + k)));
        end
        end_test();

        start_test("random");
        for (int k = 0; k < RANDOM_COUNT; k++) begin
            rnd = $urandom();
            if (rnd[1:0] == 2'b00) begin
                step(1'b0, $urandom(), taken);
            end
            send(random_inst());
        end
        end_test();

        idle(2);
        $display("summary: %0d tests, %0d retirements checked, %0d errors",
                 tests_run, retired, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
isa_pkg.sv
core_types_pkg.sv
stage_bus_if.sv
hazard_ctrl.sv
inst_decode.sv
exec_stage.sv
gpr_file.sv
rv_core_top.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_rv_core
RTL_TOP    := rv_core_top
FILELIST   := project.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --assert --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)
